// ==== hw/perint_pkg.sv ====
package perint_pkg;

	// Bus word, word address and byte selects
	typedef logic [31:0] arch_t;
	typedef logic [29:0] addr_t;
	typedef logic [3:0]  sel_t;

	// Bus operations
	typedef logic [1:0] op_t;
	localparam op_t PI1_OP_NOP   = 2'd0;
	localparam op_t PI1_OP_WRITE = 2'd1;
	localparam op_t PI1_OP_READ  = 2'd2;

	// Device slots, the last one catches unmapped addresses
	typedef logic [1:0] slot_t;
	localparam slot_t SLOT_DEVTBL  = 2'd0;
	localparam slot_t SLOT_RAM     = 2'd1;
	localparam slot_t SLOT_INVALID = 2'd2;
	localparam int    SLOT_COUNT   = 3;

	// Window sizes in bytes, laid out from word address 0 in slot order
	localparam int unsigned DEVTBL_MAPSZ  = 'h1000;
	localparam int unsigned RAM_MAPSZ     = 'h400;
	localparam int unsigned INVALID_MAPSZ = 'h1000;

	// Device ids reported by the device table
	localparam logic [7:0] DEVID_DEVTBL  = 8'd7;
	localparam logic [7:0] DEVID_RAM     = 8'd1;
	localparam logic [7:0] DEVID_INVALID = 8'd0;

	// Software reset control register
	localparam addr_t DEVTBL_CTRL_OFFSET = 30'd16;
	localparam int    CTRL_RST0_BIT      = 0;
	localparam int    CTRL_RST1_BIT      = 1;

	typedef enum logic [1:0] {
		RUN,
		HOLD,
		PWROFF
	} rst_state_t;

endpackage

// ==== hw/pi1_ifs.sv ====
`timescale 1ns/1ps

// Decoded request between decoder, queue and dispatcher
interface pi1_req_if;
	logic                valid;
	logic                take;
	perint_pkg::op_t     op;
	perint_pkg::slot_t   slot;
	perint_pkg::addr_t   offset;
	perint_pkg::arch_t   data;
	perint_pkg::sel_t    sel;

	modport src (
		output valid, op, slot, offset, data, sel,
		input  take
	);

	modport dst (
		input  valid, op, slot, offset, data, sel,
		output take
	);
endinterface

// Single device port, op held until rdy
interface pi1_slv_if;
	perint_pkg::op_t   op;
	perint_pkg::addr_t offset;
	perint_pkg::arch_t wdata;
	perint_pkg::sel_t  sel;
	perint_pkg::arch_t rdata;
	logic              rdy;

	modport master (
		output op, offset, wdata, sel,
		input  rdata, rdy
	);

	modport slave (
		input  op, offset, wdata, sel,
		output rdata, rdy
	);
endinterface

// ==== hw/rst_sequencer.sv ====
`timescale 1ns/1ps

module rst_sequencer #(
	parameter int RST_HOLD_CYCLES = 32
) (
	input  logic clk48mhz,
	input  logic rst_p,
	input  logic ctrl_rst0_i,
	input  logic ctrl_rst1_i,
	output logic sys_rst_o,
	output logic pwroff_led_n_o
);

	localparam int CNT_W = $clog2(RST_HOLD_CYCLES + 1);

	perint_pkg::rst_state_t state;
	logic [CNT_W-1:0]       hold_cnt;
	logic                   sw_cold;
	logic                   sw_warm;
	logic                   sw_pwroff;

	// Software reset requests from the control register
	assign sw_cold   = ctrl_rst0_i && ctrl_rst1_i;
	assign sw_warm   = !ctrl_rst0_i && ctrl_rst1_i;
	assign sw_pwroff = ctrl_rst0_i && !ctrl_rst1_i;

	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			state    <= perint_pkg::HOLD;
			hold_cnt <= CNT_W'(RST_HOLD_CYCLES);
		end else begin
			case (state)
				perint_pkg::PWROFF: begin
					// Latched until the external reset
					state <= perint_pkg::PWROFF;
				end
				default: begin
					if (sw_pwroff) begin
						state <= perint_pkg::PWROFF;
					end else if (sw_cold || sw_warm) begin
						// Both kinds restart the hold
						state    <= perint_pkg::HOLD;
						hold_cnt <= CNT_W'(RST_HOLD_CYCLES);
					end else if (state == perint_pkg::HOLD) begin
						if (hold_cnt <= CNT_W'(1)) begin
							state <= perint_pkg::RUN;
						end
						hold_cnt <= hold_cnt - CNT_W'(1);
					end
				end
			endcase
		end
	end

	assign sys_rst_o      = (state != perint_pkg::RUN);
	assign pwroff_led_n_o = (state != perint_pkg::PWROFF);

endmodule

// ==== hw/pi1_decoder.sv ====
`timescale 1ns/1ps

module pi1_decoder (
	input  logic              clk48mhz,
	input  logic              rst_p,
	input  perint_pkg::op_t   req_op_i,
	input  perint_pkg::addr_t req_addr_i,
	input  perint_pkg::arch_t req_data_i,
	input  perint_pkg::sel_t  req_sel_i,
	output logic              req_rdy_o,
	pi1_req_if.src            q
);

	// Cumulative window ends in words
	localparam perint_pkg::addr_t DEVTBL_LIMIT =
		perint_pkg::addr_t'(perint_pkg::DEVTBL_MAPSZ / 4);
	localparam perint_pkg::addr_t RAM_LIMIT =
		perint_pkg::addr_t'(DEVTBL_LIMIT + perint_pkg::RAM_MAPSZ / 4);

	perint_pkg::slot_t dec_slot;
	perint_pkg::addr_t dec_offset;
	logic              accept;

	always_comb begin
		if (req_addr_i < DEVTBL_LIMIT) begin
			dec_slot   = perint_pkg::SLOT_DEVTBL;
			dec_offset = req_addr_i;
		end else if (req_addr_i < RAM_LIMIT) begin
			dec_slot   = perint_pkg::SLOT_RAM;
			dec_offset = req_addr_i - DEVTBL_LIMIT;
		end else begin
			// Unmapped space falls to the default device
			dec_slot   = perint_pkg::SLOT_INVALID;
			dec_offset = req_addr_i - RAM_LIMIT;
		end
	end

	// Room when empty or the held item leaves this cycle
	assign req_rdy_o = !rst_p && (!q.valid || q.take);
	assign accept    = req_rdy_o && (req_op_i != perint_pkg::PI1_OP_NOP);

	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			q.valid <= 1'b0;
		end else if (accept) begin
			q.valid <= 1'b1;
		end else if (q.take) begin
			q.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (accept) begin
			q.op     <= req_op_i;
			q.slot   <= dec_slot;
			q.offset <= dec_offset;
			q.data   <= req_data_i;
			q.sel    <= req_sel_i;
		end
	end

endmodule

// ==== hw/pi1_req_fifo.sv ====
`timescale 1ns/1ps

module pi1_req_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic   clk48mhz,
	input  logic   rst_p,
	pi1_req_if.dst in,
	pi1_req_if.src out
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	perint_pkg::op_t   op_mem     [FIFO_DEPTH];
	perint_pkg::slot_t slot_mem   [FIFO_DEPTH];
	perint_pkg::addr_t offset_mem [FIFO_DEPTH];
	perint_pkg::arch_t data_mem   [FIFO_DEPTH];
	perint_pkg::sel_t  sel_mem    [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign push     = in.valid && (count != CNT_W'(FIFO_DEPTH));
	assign pop      = out.take;
	assign in.take  = push;
	assign out.valid = (count != '0);

	// Head item
	assign out.op     = op_mem[rd_ptr];
	assign out.slot   = slot_mem[rd_ptr];
	assign out.offset = offset_mem[rd_ptr];
	assign out.data   = data_mem[rd_ptr];
	assign out.sel    = sel_mem[rd_ptr];

	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
			if (push && !pop) begin
				count <= count + CNT_W'(1);
			end else if (pop && !push) begin
				count <= count - CNT_W'(1);
			end
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (push) begin
			op_mem[wr_ptr]     <= in.op;
			slot_mem[wr_ptr]   <= in.slot;
			offset_mem[wr_ptr] <= in.offset;
			data_mem[wr_ptr]   <= in.data;
			sel_mem[wr_ptr]    <= in.sel;
		end
	end

endmodule

// ==== hw/slave_dispatch.sv ====
`timescale 1ns/1ps

module slave_dispatch (
	input  logic              clk48mhz,
	input  logic              rst_p,
	pi1_req_if.dst            q,
	pi1_slv_if.master         devtbl,
	pi1_slv_if.master         ram,
	output logic              rsp_valid_o,
	output perint_pkg::arch_t rsp_data_o
);

	typedef enum logic {
		IDLE,
		ACCESS
	} disp_state_t;

	disp_state_t       state;
	logic              dev_rdy;
	perint_pkg::arch_t dev_rdata;
	logic              to_invalid;
	logic              done;

	always_comb begin
		case (q.slot)
			perint_pkg::SLOT_DEVTBL: begin
				dev_rdy   = devtbl.rdy;
				dev_rdata = devtbl.rdata;
			end
			perint_pkg::SLOT_RAM: begin
				dev_rdy   = ram.rdy;
				dev_rdata = ram.rdata;
			end
			default: begin
				// Default device reads as zero
				dev_rdy   = 1'b0;
				dev_rdata = '0;
			end
		endcase
	end

	// Default device completes straight from IDLE
	assign to_invalid = (state == IDLE) && q.valid && (q.slot == perint_pkg::SLOT_INVALID);
	assign done       = to_invalid || ((state == ACCESS) && dev_rdy);
	assign q.take     = done;

	assign devtbl.op     = ((state == ACCESS) && (q.slot == perint_pkg::SLOT_DEVTBL)) ?
		q.op : perint_pkg::PI1_OP_NOP;
	assign devtbl.offset = q.offset;
	assign devtbl.wdata  = q.data;
	assign devtbl.sel    = q.sel;

	assign ram.op     = ((state == ACCESS) && (q.slot == perint_pkg::SLOT_RAM)) ?
		q.op : perint_pkg::PI1_OP_NOP;
	assign ram.offset = q.offset;
	assign ram.wdata  = q.data;
	assign ram.sel    = q.sel;

	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			state       <= IDLE;
			rsp_valid_o <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (q.valid && (q.slot != perint_pkg::SLOT_INVALID)) begin
						state <= ACCESS;
					end
				end
				ACCESS: begin
					if (dev_rdy) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			rsp_valid_o <= done && (q.op == perint_pkg::PI1_OP_READ);
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (done) begin
			rsp_data_o <= dev_rdata;
		end
	end

endmodule

// ==== hw/dev_table.sv ====
`timescale 1ns/1ps

module dev_table (
	input  logic      clk48mhz,
	input  logic      rst_p,
	pi1_slv_if.slave  bus,
	output logic      ctrl_rst0_o,
	output logic      ctrl_rst1_o
);

	perint_pkg::arch_t rd_word;
	perint_pkg::arch_t rdata_q;
	perint_pkg::slot_t entry;
	perint_pkg::arch_t mapsz;
	logic [7:0]        id;
	logic              rdy_q;
	logic              access;

	assign access = (bus.op != perint_pkg::PI1_OP_NOP) && !rdy_q;
	assign entry  = perint_pkg::slot_t'(bus.offset >> 1);

	always_comb begin
		case (entry)
			perint_pkg::SLOT_DEVTBL: begin
				id    = perint_pkg::DEVID_DEVTBL;
				mapsz = perint_pkg::arch_t'(perint_pkg::DEVTBL_MAPSZ);
			end
			perint_pkg::SLOT_RAM: begin
				id    = perint_pkg::DEVID_RAM;
				mapsz = perint_pkg::arch_t'(perint_pkg::RAM_MAPSZ);
			end
			default: begin
				id    = perint_pkg::DEVID_INVALID;
				mapsz = perint_pkg::arch_t'(perint_pkg::INVALID_MAPSZ);
			end
		endcase

		rd_word = '0;
		if (bus.offset < perint_pkg::addr_t'(2 * perint_pkg::SLOT_COUNT)) begin
			// Even word holds the id and the interrupt bit 8, which no device sets
			// Odd word holds the map size
			rd_word = bus.offset[0] ? mapsz : {23'd0, 1'b0, id};
		end else if (bus.offset == perint_pkg::DEVTBL_CTRL_OFFSET) begin
			rd_word[perint_pkg::CTRL_RST0_BIT] = ctrl_rst0_o;
			rd_word[perint_pkg::CTRL_RST1_BIT] = ctrl_rst1_o;
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			rdy_q       <= 1'b0;
			ctrl_rst0_o <= 1'b0;
			ctrl_rst1_o <= 1'b0;
		end else begin
			rdy_q <= access;
			if (access && (bus.op == perint_pkg::PI1_OP_WRITE) &&
				(bus.offset == perint_pkg::DEVTBL_CTRL_OFFSET) && bus.sel[0]) begin
				ctrl_rst0_o <= bus.wdata[perint_pkg::CTRL_RST0_BIT];
				ctrl_rst1_o <= bus.wdata[perint_pkg::CTRL_RST1_BIT];
			end
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (access) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;

endmodule

// ==== hw/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram #(
	parameter int RAM_WAIT_CYCLES = 3
) (
	input  logic     clk48mhz,
	input  logic     rst_p,
	pi1_slv_if.slave bus
);

	localparam int WORDS  = perint_pkg::RAM_MAPSZ / 4;
	localparam int IDX_W  = $clog2(WORDS);
	localparam int WAIT_W = (RAM_WAIT_CYCLES > 0) ? $clog2(RAM_WAIT_CYCLES + 1) : 1;

	perint_pkg::arch_t mem [WORDS];
	perint_pkg::arch_t rdata_q;
	logic [IDX_W-1:0]  idx;
	logic [WAIT_W-1:0] wait_cnt;
	logic              rdy_q;
	logic              fire;

	assign idx = bus.offset[IDX_W-1:0];

	// Access happens once the wait count is used up
	assign fire = (bus.op != perint_pkg::PI1_OP_NOP) && !rdy_q &&
		(wait_cnt == WAIT_W'(RAM_WAIT_CYCLES));

	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			rdy_q    <= 1'b0;
			wait_cnt <= '0;
		end else begin
			rdy_q <= fire;
			if (fire || (bus.op == perint_pkg::PI1_OP_NOP)) begin
				wait_cnt <= '0;
			end else if (!rdy_q) begin
				wait_cnt <= wait_cnt + WAIT_W'(1);
			end
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (fire) begin
			rdata_q <= mem[idx];
			if (bus.op == perint_pkg::PI1_OP_WRITE) begin
				for (int b = 0; b < 4; b++) begin
					if (bus.sel[b]) begin
						mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;

endmodule

// ==== hw/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
	parameter int FIFO_DEPTH      = 4,
	parameter int RAM_WAIT_CYCLES = 3,
	parameter int RST_HOLD_CYCLES = 32
) (
	input  logic              rst_p,
	input  logic              clk48mhz,
	input  perint_pkg::op_t   req_op_i,
	input  perint_pkg::addr_t req_addr_i,
	input  perint_pkg::arch_t req_data_i,
	input  perint_pkg::sel_t  req_sel_i,
	output logic              req_rdy_o,
	output logic              rsp_valid_o,
	output perint_pkg::arch_t rsp_data_o,
	output logic              pwroff_led_n_o
);

	logic sys_rst;
	logic ctrl_rst0;
	logic ctrl_rst1;

	pi1_req_if dec_q ();
	pi1_req_if fifo_q ();
	pi1_slv_if devtbl_bus ();
	pi1_slv_if ram_bus ();

	rst_sequencer #(.RST_HOLD_CYCLES(RST_HOLD_CYCLES)) u_rst_seq (
		.clk48mhz       (clk48mhz),
		.rst_p          (rst_p),
		.ctrl_rst0_i    (ctrl_rst0),
		.ctrl_rst1_i    (ctrl_rst1),
		.sys_rst_o      (sys_rst),
		.pwroff_led_n_o (pwroff_led_n_o)
	);

	pi1_decoder u_decoder (
		.clk48mhz   (clk48mhz),
		.rst_p      (sys_rst),
		.req_op_i   (req_op_i),
		.req_addr_i (req_addr_i),
		.req_data_i (req_data_i),
		.req_sel_i  (req_sel_i),
		.req_rdy_o  (req_rdy_o),
		.q          (dec_q)
	);

	pi1_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_req_fifo (
		.clk48mhz (clk48mhz),
		.rst_p    (sys_rst),
		.in       (dec_q),
		.out      (fifo_q)
	);

	slave_dispatch u_dispatch (
		.clk48mhz    (clk48mhz),
		.rst_p       (sys_rst),
		.q           (fifo_q),
		.devtbl      (devtbl_bus),
		.ram         (ram_bus),
		.rsp_valid_o (rsp_valid_o),
		.rsp_data_o  (rsp_data_o)
	);

	dev_table u_devtbl (
		.clk48mhz    (clk48mhz),
		.rst_p       (sys_rst),
		.bus         (devtbl_bus),
		.ctrl_rst0_o (ctrl_rst0),
		.ctrl_rst1_o (ctrl_rst1)
	);

	scratch_ram #(.RAM_WAIT_CYCLES(RAM_WAIT_CYCLES)) u_ram (
		.clk48mhz (clk48mhz),
		.rst_p    (sys_rst),
		.bus      (ram_bus)
	);

endmodule

// ==== dv/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb;

	localparam int FIFO_DEPTH      = 4;
	localparam int RAM_WAIT_CYCLES = 3;
	localparam int RST_HOLD_CYCLES = 32;

	logic              clk48mhz;
	logic              rst_p;
	perint_pkg::op_t   req_op_i;
	perint_pkg::addr_t req_addr_i;
	perint_pkg::arch_t req_data_i;
	perint_pkg::sel_t  req_sel_i;
	logic              req_rdy_o;
	logic              rsp_valid_o;
	perint_pkg::arch_t rsp_data_o;
	logic              pwroff_led_n_o;

	// Parsed stimulus lines
	string       line_name [$];
	string       line_cmd  [$];
	logic [31:0] line_addr [$];
	logic [31:0] line_data [$];
	logic [31:0] line_sel  [$];
	logic [31:0] line_exp  [$];

	// Reads in flight, oldest first
	string       pend_name [$];
	logic [31:0] pend_exp  [$];

	int   errors;
	int   cycle_cnt;
	int   cycle_limit;
	logic stall_seen;

	soc_top #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.RAM_WAIT_CYCLES (RAM_WAIT_CYCLES),
		.RST_HOLD_CYCLES (RST_HOLD_CYCLES)
	) UUT (
		.rst_p          (rst_p),
		.clk48mhz       (clk48mhz),
		.req_op_i       (req_op_i),
		.req_addr_i     (req_addr_i),
		.req_data_i     (req_data_i),
		.req_sel_i      (req_sel_i),
		.req_rdy_o      (req_rdy_o),
		.rsp_valid_o    (rsp_valid_o),
		.rsp_data_o     (rsp_data_o),
		.pwroff_led_n_o (pwroff_led_n_o)
	);

	initial begin
		clk48mhz = 1'b0;
		forever #2 clk48mhz = ~clk48mhz;
	end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic load_stimulus();
		int          fd;
		int          n;
		string       text;
		string       nm;
		string       cm;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] s;
		logic [31:0] e;
		fd = $fopen("dv/soc_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file dv/soc_stimulus.txt");
			return;
		end
		while (!$feof(fd)) begin
			text = "";
			void'($fgets(text, fd));
			if (text.len() < 2 || text[0] == "#") begin
				continue;
			end
			n = $sscanf(text, "%s %s %h %h %h %h", nm, cm, a, d, s, e);
			if (n == 6) begin
				line_name.push_back(nm);
				line_cmd.push_back(cm);
				line_addr.push_back(a);
				line_data.push_back(d);
				line_sel.push_back(s);
				line_exp.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	task automatic set_idle();
		@(negedge clk48mhz);
		req_op_i = perint_pkg::PI1_OP_NOP;
	endtask

	// Holds the request until the decoder has room
	task automatic issue_request(input perint_pkg::op_t op, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] sel);
		@(negedge clk48mhz);
		req_op_i   = op;
		req_addr_i = addr[29:0];
		req_data_i = data;
		req_sel_i  = sel[3:0];
		while (req_rdy_o !== 1'b1) begin
			stall_seen = 1'b1;
			@(negedge clk48mhz);
		end
	endtask

	task automatic wait_ready();
		set_idle();
		while (req_rdy_o !== 1'b1 || pend_exp.size() != 0) begin
			@(negedge clk48mhz);
		end
		stall_seen = 1'b0;
	endtask

	// Zero cycles checks that the decoder stalled since the last wait
	task automatic check_ready_low(input string name, input int cycles,
		input logic [31:0] led_exp);
		set_idle();
		if (cycles == 0) begin
			check_value({name, " stall"}, 32'd1, {31'd0, stall_seen});
		end else begin
			while (req_rdy_o !== 1'b0) begin
				@(negedge clk48mhz);
			end
			repeat (cycles) begin
				check_value({name, " rdy"}, 32'd0, {31'd0, req_rdy_o});
				check_value({name, " led"}, led_exp, {31'd0, pwroff_led_n_o});
				@(negedge clk48mhz);
			end
		end
	endtask

	task automatic pulse_reset();
		set_idle();
		rst_p = 1'b1;
		repeat (8) @(negedge clk48mhz);
		rst_p = 1'b0;
		pend_name.delete();
		pend_exp.delete();
	endtask

	// Responses come back in issue order
	always @(negedge clk48mhz) begin
		if (!rst_p && rsp_valid_o === 1'b1) begin
			if (pend_exp.size() == 0) begin
				errors++;
				$display("read response %08h arrived with no read pending", rsp_data_o);
			end else begin
				check_value(pend_name.pop_front(), pend_exp.pop_front(), rsp_data_o);
			end
		end
	end

	always @(posedge clk48mhz) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("errors: %0d", errors + 1);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		rst_p       = 1'b1;
		req_op_i    = perint_pkg::PI1_OP_NOP;
		req_addr_i  = '0;
		req_data_i  = '0;
		req_sel_i   = '0;
		errors      = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		stall_seen  = 1'b0;
		load_stimulus();
		cycle_limit = line_cmd.size() * 64 + 4 * RST_HOLD_CYCLES;

		repeat (8) @(negedge clk48mhz);
		rst_p = 1'b0;
		wait_ready();

		for (int i = 0; i < line_cmd.size(); i++) begin
			case (line_cmd[i])
				"write": begin
					issue_request(perint_pkg::PI1_OP_WRITE, line_addr[i], line_data[i],
						line_sel[i]);
				end
				"read": begin
					issue_request(perint_pkg::PI1_OP_READ, line_addr[i], line_data[i],
						line_sel[i]);
					pend_name.push_back(line_name[i]);
					pend_exp.push_back(line_exp[i]);
				end
				"rdylow": check_ready_low(line_name[i], int'(line_data[i]), line_exp[i]);
				"waitrdy": wait_ready();
				"reset": pulse_reset();
				default: begin
					errors++;
					$display("unknown command %s in test %s", line_cmd[i], line_name[i]);
				end
			endcase
		end
		wait_ready();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/soc_stimulus.txt ====
# test command addr data sel expected, all numbers hex, addr is a word address
# rdylow: data is the cycle count to hold low (0 checks for a stall), expected is the LED level
devtbl read 00000000 00000000 f 00000007
devtbl read 00000001 00000000 f 00001000
devtbl read 00000002 00000000 f 00000001
devtbl read 00000003 00000000 f 00000400
devtbl read 00000004 00000000 f 00000000
devtbl read 00000005 00000000 f 00001000
devtbl read 00000010 00000000 f 00000000
ram write 00000400 11223344 f 00000000
ram write 00000401 aabbccdd f 00000000
ram write 00000400 000000ee 1 00000000
ram write 00000401 99000000 8 00000000
ram read 00000400 00000000 f 112233ee
ram read 00000401 00000000 f 99bbccdd
ram write 00000400 00aa5500 6 00000000
ram read 00000400 00000000 f 11aa55ee
invalid read 00000500 00000000 f 00000000
invalid write 00000500 deadbeef f 00000000
invalid read 00000600 00000000 f 00000000
invalid read 00000400 00000000 f 11aa55ee
invalid waitrdy 00000000 00000000 0 00000000
queue write 00000410 a0a0a0a0 f 00000000
queue write 00000411 a1a1a1a1 f 00000000
queue write 00000412 a2a2a2a2 f 00000000
queue write 00000413 a3a3a3a3 f 00000000
queue read 00000410 00000000 f a0a0a0a0
queue read 00000411 00000000 f a1a1a1a1
queue write 00000414 5eed0414 f 00000000
queue read 00000412 00000000 f a2a2a2a2
queue read 00000413 00000000 f a3a3a3a3
queue read 00000414 00000000 f 5eed0414
queue rdylow 00000000 00000000 0 00000001
queue waitrdy 00000000 00000000 0 00000000
warm write 00000010 00000002 1 00000000
warm rdylow 00000000 00000010 0 00000001
warm waitrdy 00000000 00000000 0 00000000
warm read 00000010 00000000 f 00000000
warm read 00000401 00000000 f 99bbccdd
cold write 00000010 00000003 1 00000000
cold rdylow 00000000 00000010 0 00000001
cold waitrdy 00000000 00000000 0 00000000
cold read 00000010 00000000 f 00000000
cold read 00000400 00000000 f 11aa55ee
pwroff write 00000010 00000001 1 00000000
pwroff rdylow 00000000 00000040 0 00000000
pwroff reset 00000000 00000000 0 00000000
pwroff waitrdy 00000000 00000000 0 00000000
pwroff read 00000413 00000000 f a3a3a3a3
pwroff read 00000010 00000000 f 00000000

// ==== tb.f ====
hw/perint_pkg.sv
hw/pi1_ifs.sv
hw/rst_sequencer.sv
hw/pi1_decoder.sv
hw/pi1_req_fifo.sv
hw/slave_dispatch.sv
hw/dev_table.sv
hw/scratch_ram.sv
hw/soc_top.sv
dv/soc_tb.sv
